/* hdl/xm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and register map of the host register
// interface. Holds the register numbers and the bit
// positions of the SYS_CTRL status fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xm_pkg;

typedef logic [15:0] word_t;    // register or vram data word
typedef logic [15:0] addr_t;    // vram word address
typedef logic [7:0]  byte_t;    // host bus byte

// host visible register numbers
typedef enum logic [3:0] {
    XM_SYS_CTRL  = 4'h0,
    XM_INT_CTRL  = 4'h1,        // dropped, reads zero
    XM_TIMER     = 4'h2,
    XM_RD_XADDR  = 4'h3,        // dropped
    XM_WR_XADDR  = 4'h4,        // dropped
    XM_XDATA     = 4'h5,        // dropped
    XM_RD_INCR   = 4'h6,
    XM_RD_ADDR   = 4'h7,
    XM_WR_INCR   = 4'h8,
    XM_WR_ADDR   = 4'h9,
    XM_DATA      = 4'hA,
    XM_DATA_2    = 4'hB,
    XM_UNUSED_0C = 4'hC,
    XM_UNUSED_0D = 4'hD,
    XM_UNUSED_0E = 4'hE,
    XM_UNUSED_0F = 4'hF
} xm_reg_e;

// SYS_CTRL field positions
localparam int SYS_MEM_WAIT_BIT = 15;   // vram access in progress
localparam int SYS_HBLANK_BIT   = 11;
localparam int SYS_VBLANK_BIT   = 10;
localparam int WRMASK_W         = 4;    // nibble write mask width

endpackage

`default_nettype wire

/* hdl/bus_sync.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus synchronizer. Brings the asynchronous
// 8-bit bus into the clock domain and turns each bus
// cycle into one read strobe or one write strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module bus_sync (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            bus_cs_n_i,        // chip select, active low
    input  wire logic            bus_rd_nwr_i,      // 1 read, 0 write
    input  wire logic [3:0]      bus_reg_num_i,
    input  wire logic            bus_bytesel_i,     // 0 even byte, 1 odd byte
    input  wire xm_pkg::byte_t   bus_data_i,
    output      logic            wr_strobe_o,
    output      logic            rd_strobe_o,
    output      xm_pkg::xm_reg_e reg_num_o,
    output      logic            bytesel_o,
    output      xm_pkg::byte_t   bytedata_o
);
    import xm_pkg::*;

    logic [2:0] cs_n_sync;          // two sync stages plus previous value
    logic [1:0] rd_nwr_sync;
    logic [3:0] reg_num_ff1;
    logic [3:0] reg_num_ff2;
    logic       bytesel_ff1;
    logic       bytesel_ff2;
    byte_t      data_ff1;
    byte_t      data_ff2;
    logic       cs_fall;

    assign cs_fall = cs_n_sync[2] & ~cs_n_sync[1];  // synchronized select just went low

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync   <= 3'b111;
            rd_nwr_sync <= 2'b11;
            wr_strobe_o <= 1'b0;
            rd_strobe_o <= 1'b0;
        end else begin
            cs_n_sync   <= {cs_n_sync[1:0], bus_cs_n_i};
            rd_nwr_sync <= {rd_nwr_sync[0], bus_rd_nwr_i};
            wr_strobe_o <= cs_fall & ~rd_nwr_sync[1];
            rd_strobe_o <= cs_fall & rd_nwr_sync[1];
        end
    end

    // bus payload, stable while select is low
    always_ff @(posedge clk) begin
        reg_num_ff1 <= bus_reg_num_i;
        reg_num_ff2 <= reg_num_ff1;
        bytesel_ff1 <= bus_bytesel_i;
        bytesel_ff2 <= bytesel_ff1;
        data_ff1    <= bus_data_i;
        data_ff2    <= data_ff1;
        if (cs_fall) begin
            reg_num_o  <= xm_reg_e'(reg_num_ff2);  // held until next strobe
            bytesel_o  <= bytesel_ff2;
            bytedata_o <= data_ff2;
        end
    end

endmodule

`default_nettype wire

/* hdl/tick_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free running 16-bit timer in steps of 1/10 ms.
// A fractional accumulator divides the clock by the
// ratio TIMER_CLK_REDUCED / TIMER_HZ_REDUCED.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tick_timer #(
    parameter int TIMER_CLK_REDUCED = 5025,     // clock side of reduced fraction
    parameter int TIMER_HZ_REDUCED  = 2         // timer side of reduced fraction
) (
    input  wire logic          clk,
    input  wire logic          reset_i,
    output      xm_pkg::word_t timer_count_o
);

    localparam int FRAC_BITS = $clog2(TIMER_CLK_REDUCED) + 1;  // extra bit is the sign

    localparam logic [FRAC_BITS-1:0] STEP_TICK =
        FRAC_BITS'(TIMER_HZ_REDUCED - TIMER_CLK_REDUCED);
    localparam logic [FRAC_BITS-1:0] STEP_IDLE = FRAC_BITS'(TIMER_HZ_REDUCED);

    logic [FRAC_BITS-1:0] frac_acc;
    logic                 tick;

    assign tick = ~frac_acc[FRAC_BITS-1];   // accumulator back to non negative

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac_acc      <= '0;
            timer_count_o <= '0;
        end else begin
            if (tick) begin
                frac_acc      <= frac_acc + STEP_TICK;
                timer_count_o <= timer_count_o + 16'd1;
            end else begin
                frac_acc      <= frac_acc + STEP_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/xm_reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file of the host interface. Decodes byte
// writes and reads, keeps the VRAM address and
// increment registers, issues VRAM reads and writes
// and drives the read-back byte.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xm_reg_file (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          wr_strobe_i,
    input  wire logic                          rd_strobe_i,
    input  wire xm_pkg::xm_reg_e               reg_num_i,
    input  wire logic                          bytesel_i,     // 0 even (high) byte
    input  wire xm_pkg::byte_t                 bytedata_i,
    input  wire xm_pkg::word_t                 timer_count_i,
    input  wire logic                          h_blank_i,
    input  wire logic                          v_blank_i,
    input  wire logic                          vram_ack_i,
    input  wire xm_pkg::word_t                 vram_data_i,
    output      xm_pkg::byte_t                 bus_data_o,
    output      logic                          vram_sel_o,
    output      logic                          vram_wr_o,
    output      logic [xm_pkg::WRMASK_W-1:0]   vram_wrmask_o,
    output      xm_pkg::addr_t                 vram_addr_o,
    output      xm_pkg::word_t                 vram_data_o
);
    import xm_pkg::*;

    word_t  reg_rd_incr;
    addr_t  reg_rd_addr;
    word_t  reg_wr_incr;
    addr_t  reg_wr_addr;
    word_t  reg_data;           // last word read from vram
    byte_t  reg_data_even;      // high byte of DATA waiting for low byte
    byte_t  timer_latch;        // timer low byte at last high byte read
    logic   rd_incr_flag;
    logic   wr_incr_flag;
    logic   mem_wait;
    word_t  rd_word;

    // busy until the address has advanced after the ack
    assign mem_wait = vram_sel_o | rd_incr_flag | wr_incr_flag;

    always_comb begin
        rd_word = '0;
        case (reg_num_i)
            XM_SYS_CTRL: begin
                rd_word[SYS_MEM_WAIT_BIT] = mem_wait;
                rd_word[SYS_HBLANK_BIT]   = h_blank_i;
                rd_word[SYS_VBLANK_BIT]   = v_blank_i;
                rd_word[WRMASK_W-1:0]     = vram_wrmask_o;
            end
            XM_TIMER:   rd_word = {timer_count_i[15:8], timer_latch};
            XM_RD_INCR: rd_word = reg_rd_incr;
            XM_RD_ADDR: rd_word = reg_rd_addr;
            XM_WR_INCR: rd_word = reg_wr_incr;
            XM_WR_ADDR: rd_word = reg_wr_addr;
            XM_DATA,
            XM_DATA_2:  rd_word = reg_data;
            default:    rd_word = '0;               // dropped and unused registers
        endcase
    end

    assign bus_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            vram_wr_o     <= 1'b0;
            vram_wrmask_o <= '1;
            vram_addr_o   <= '0;
            vram_data_o   <= '0;
            reg_rd_incr   <= '0;
            reg_rd_addr   <= '0;
            reg_wr_incr   <= '0;
            reg_wr_addr   <= '0;
            reg_data      <= '0;
            reg_data_even <= '0;
            timer_latch   <= '0;
            rd_incr_flag  <= 1'b0;
            wr_incr_flag  <= 1'b0;
        end else begin
            rd_incr_flag <= 1'b0;
            wr_incr_flag <= 1'b0;

            if (vram_sel_o && vram_ack_i) begin
                if (vram_wr_o) begin
                    wr_incr_flag <= 1'b1;
                end else begin
                    reg_data     <= vram_data_i;    // read data valid in ack cycle
                    rd_incr_flag <= 1'b1;
                end
                vram_sel_o <= 1'b0;
                vram_wr_o  <= 1'b0;
            end

            if (rd_incr_flag) begin
                reg_rd_addr <= reg_rd_addr + reg_rd_incr;
            end
            if (wr_incr_flag) begin
                reg_wr_addr <= reg_wr_addr + reg_wr_incr;
            end

            if (wr_strobe_i) begin
                case (reg_num_i)
                    XM_SYS_CTRL: begin
                        if (bytesel_i) begin
                            vram_wrmask_o <= bytedata_i[WRMASK_W-1:0];
                        end
                    end
                    XM_RD_INCR: begin
                        if (!bytesel_i) begin
                            reg_rd_incr[15:8] <= bytedata_i;
                        end else begin
                            reg_rd_incr[7:0]  <= bytedata_i;
                        end
                    end
                    XM_RD_ADDR: begin
                        if (!bytesel_i) begin
                            reg_rd_addr[15:8] <= bytedata_i;
                        end else begin
                            reg_rd_addr[7:0]  <= bytedata_i;
                            if (!mem_wait) begin            // read at the new address
                                vram_sel_o  <= 1'b1;
                                vram_wr_o   <= 1'b0;
                                vram_addr_o <= {reg_rd_addr[15:8], bytedata_i};
                            end
                        end
                    end
                    XM_WR_INCR: begin
                        if (!bytesel_i) begin
                            reg_wr_incr[15:8] <= bytedata_i;
                        end else begin
                            reg_wr_incr[7:0]  <= bytedata_i;
                        end
                    end
                    XM_WR_ADDR: begin
                        if (!bytesel_i) begin
                            reg_wr_addr[15:8] <= bytedata_i;
                        end else begin
                            reg_wr_addr[7:0]  <= bytedata_i;
                        end
                    end
                    XM_DATA,
                    XM_DATA_2: begin
                        if (!bytesel_i) begin
                            reg_data_even <= bytedata_i;
                        end else if (!mem_wait) begin   // whole word write
                            vram_sel_o  <= 1'b1;
                            vram_wr_o   <= 1'b1;
                            vram_addr_o <= reg_wr_addr;
                            vram_data_o <= {reg_data_even, bytedata_i};
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (rd_strobe_i) begin
                if (!bytesel_i && reg_num_i == XM_TIMER) begin
                    timer_latch <= timer_count_i[7:0];
                end
                // pre-read of the next word after the low byte of DATA
                if (bytesel_i && (reg_num_i == XM_DATA || reg_num_i == XM_DATA_2)
                    && !mem_wait) begin
                    vram_sel_o  <= 1'b1;
                    vram_wr_o   <= 1'b0;
                    vram_addr_o <= reg_rd_addr;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/xm_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register interface of the video controller.
// Ties the bus synchronizer, the 1/10 ms timer and
// the register file together.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xm_regs #(
    parameter int TIMER_CLK_REDUCED = 5025,
    parameter int TIMER_HZ_REDUCED  = 2
) (
    input  wire logic                          clk,
    input  wire logic                          reset_i,
    input  wire logic                          bus_cs_n_i,
    input  wire logic                          bus_rd_nwr_i,
    input  wire logic [3:0]                    bus_reg_num_i,
    input  wire logic                          bus_bytesel_i,
    input  wire xm_pkg::byte_t                 bus_data_i,
    output      xm_pkg::byte_t                 bus_data_o,
    input  wire logic                          vram_ack_i,
    input  wire xm_pkg::word_t                 vram_data_i,
    output      logic                          vram_sel_o,
    output      logic                          vram_wr_o,
    output      logic [xm_pkg::WRMASK_W-1:0]   vram_wrmask_o,
    output      xm_pkg::addr_t                 vram_addr_o,
    output      xm_pkg::word_t                 vram_data_o,
    input  wire logic                          h_blank_i,
    input  wire logic                          v_blank_i
);
    import xm_pkg::*;

    logic    wr_strobe;
    logic    rd_strobe;
    xm_reg_e reg_num;
    logic    bytesel;
    byte_t   bytedata;
    word_t   timer_count;

    bus_sync u_bus_sync (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .wr_strobe_o   (wr_strobe),
        .rd_strobe_o   (rd_strobe),
        .reg_num_o     (reg_num),
        .bytesel_o     (bytesel),
        .bytedata_o    (bytedata)
    );

    tick_timer #(
        .TIMER_CLK_REDUCED (TIMER_CLK_REDUCED),
        .TIMER_HZ_REDUCED  (TIMER_HZ_REDUCED)
    ) u_tick_timer (
        .clk           (clk),
        .reset_i       (reset_i),
        .timer_count_o (timer_count)
    );

    xm_reg_file u_reg_file (
        .clk           (clk),
        .reset_i       (reset_i),
        .wr_strobe_i   (wr_strobe),
        .rd_strobe_i   (rd_strobe),
        .reg_num_i     (reg_num),
        .bytesel_i     (bytesel),
        .bytedata_i    (bytedata),
        .timer_count_i (timer_count),
        .h_blank_i     (h_blank_i),
        .v_blank_i     (v_blank_i),
        .vram_ack_i    (vram_ack_i),
        .vram_data_i   (vram_data_i),
        .bus_data_o    (bus_data_o),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_wrmask_o (vram_wrmask_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o)
    );

endmodule

`default_nettype wire

/* dv/xm_regs_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the VRAM port of the
// register file, attached with bind.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xm_regs_asserts (
    input wire logic          clk,
    input wire logic          reset_i,
    input wire logic          vram_sel_o,
    input wire logic          vram_wr_o,
    input wire logic          vram_ack_i,
    input wire xm_pkg::addr_t vram_addr_o,
    input wire xm_pkg::word_t vram_data_o
);

    int assert_failures = 0;        // read by the testbench at the end

    a_wr_has_sel: assert property (@(posedge clk) disable iff (reset_i)
        vram_wr_o |-> vram_sel_o)
        else begin assert_failures++; $error("vram write flag without select"); end

    // request held until acked
    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o && !vram_ack_i) |=> (vram_sel_o && $stable(vram_wr_o)
            && $stable(vram_addr_o) && $stable(vram_data_o)))
        else begin assert_failures++; $error("vram request changed before ack"); end

    a_reset_idle: assert property (@(posedge clk) reset_i |=> !vram_sel_o)
        else begin assert_failures++; $error("vram select high after reset"); end

endmodule

bind xm_reg_file xm_regs_asserts u_reg_asserts (
    .clk         (clk),
    .reset_i     (reset_i),
    .vram_sel_o  (vram_sel_o),
    .vram_wr_o   (vram_wr_o),
    .vram_ack_i  (vram_ack_i),
    .vram_addr_o (vram_addr_o),
    .vram_data_o (vram_data_o)
);

`default_nettype wire

/* dv/tb_xm_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the host register interface. Random
// byte accesses on the host bus, a VRAM model with
// random ack latency and a register model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_xm_regs;
    import xm_pkg::*;

    localparam int CLK_DIV    = 7;      // timer advances once per 7 clocks
    localparam int IDLE_POLLS = 40;

    logic                clk = 1'b0;
    logic                reset_i;
    logic                bus_cs_n_i;
    logic                bus_rd_nwr_i;
    logic [3:0]          bus_reg_num_i;
    logic                bus_bytesel_i;
    byte_t               bus_data_i;
    byte_t               bus_data_o;
    logic                vram_ack_i = 1'b0;
    word_t               vram_data_i = '0;
    logic                vram_sel_o;
    logic                vram_wr_o;
    logic [WRMASK_W-1:0] vram_wrmask_o;
    addr_t               vram_addr_o;
    word_t               vram_data_o;
    logic                h_blank_i;
    logic                v_blank_i;

    integer  seed = 86;
    integer  lat_seed = 86;             // separate stream for the memory model
    int      errors = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    int      cycle_cnt = 0;
    word_t   vram_mem [0:65535];
    int      lat_left = 0;
    logic    pending = 1'b0;
    addr_t   exp_rd_addr;               // register model
    addr_t   exp_wr_addr;
    word_t   exp_rd_incr;
    word_t   exp_wr_incr;
    logic [3:0] exp_mask;
    xm_reg_e dropped_regs [8] = '{XM_INT_CTRL, XM_RD_XADDR, XM_WR_XADDR, XM_XDATA,
                                  XM_UNUSED_0C, XM_UNUSED_0D, XM_UNUSED_0E, XM_UNUSED_0F};

    xm_regs #(
        .TIMER_CLK_REDUCED (7),
        .TIMER_HZ_REDUCED  (1)
    ) u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .vram_ack_i    (vram_ack_i),
        .vram_data_i   (vram_data_i),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_wrmask_o (vram_wrmask_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o),
        .h_blank_i     (h_blank_i),
        .v_blank_i     (v_blank_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic word_t merge_nibbles(word_t old_w, word_t new_w, logic [3:0] mask);
        word_t res;
        res = old_w;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) res[n*4 +: 4] = new_w[n*4 +: 4];   // enabled nibble takes new data
        end
        return res;
    endfunction

    // vram model, acks each select after 1 to 4 cycles
    always @(posedge clk) begin
        vram_ack_i <= 1'b0;
        if (reset_i) begin
            pending = 1'b0;
            for (int i = 0; i < 65536; i++) begin
                vram_mem[i] = word_t'(i) * 16'h9e37 + 16'h1234;
            end
        end else if (vram_sel_o && !vram_ack_i) begin
            if (!pending) begin
                pending  = 1'b1;
                lat_left = 1 + int'($unsigned($random(lat_seed)) % 32'd4);
            end
            lat_left = lat_left - 1;
            if (lat_left == 0) begin
                pending = 1'b0;
                vram_ack_i <= 1'b1;
                if (vram_wr_o) begin
                    vram_mem[vram_addr_o] = merge_nibbles(vram_mem[vram_addr_o], vram_data_o,
                                                          vram_wrmask_o);
                end else begin
                    vram_data_i <= vram_mem[vram_addr_o];
                end
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // one bus cycle, select low for 6 clocks and high for 4
    task automatic bus_cycle(input logic rd, input xm_reg_e regn, input logic odd,
                             input byte_t wdata, output byte_t rdata);
        @(posedge clk);
        bus_rd_nwr_i  <= rd;
        bus_reg_num_i <= regn;
        bus_bytesel_i <= odd;
        bus_data_i    <= wdata;
        bus_cs_n_i    <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rdata = bus_data_o;                 // last low cycle
        @(posedge clk);
        bus_cs_n_i <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic write_word(input xm_reg_e regn, input word_t w);
        byte_t ignored;
        bus_cycle(1'b0, regn, 1'b0, w[15:8], ignored);
        bus_cycle(1'b0, regn, 1'b1, w[7:0], ignored);
    endtask

    task automatic read_word(input xm_reg_e regn, output word_t w);
        byte_t hi;
        byte_t lo;
        bus_cycle(1'b1, regn, 1'b0, 8'h00, hi);
        bus_cycle(1'b1, regn, 1'b1, 8'h00, lo);
        w = {hi, lo};
    endtask

    task automatic wait_idle();
        byte_t status;
        int    polls;
        polls  = 0;
        status = 8'h80;
        while (status[SYS_MEM_WAIT_BIT-8] && polls < IDLE_POLLS) begin
            bus_cycle(1'b1, XM_SYS_CTRL, 1'b0, 8'h00, status);
            polls++;
        end
        if (status[SYS_MEM_WAIT_BIT-8]) abort_run("busy flag never cleared");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail @%0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    // word writes to DATA or DATA_2, checked in the model memory
    task automatic stream_write(input int count);
        word_t w;
        word_t exp_w;
        word_t rd_w;
        for (int i = 0; i < count; i++) begin
            w     = word_t'($random(seed));
            exp_w = merge_nibbles(vram_mem[exp_wr_addr], w, exp_mask);
            write_word(1'($random(seed)) ? XM_DATA_2 : XM_DATA, w);
            wait_idle();
            check_word("vram word after write", vram_mem[exp_wr_addr], exp_w);
            exp_wr_addr = exp_wr_addr + exp_wr_incr;
        end
        read_word(XM_WR_ADDR, rd_w);
        check_word("WR_ADDR after writes", rd_w, exp_wr_addr);
    endtask

    task automatic read_timer(output word_t t, output int at_cycle);
        byte_t hi;
        byte_t lo;
        int    tries;
        tries = 0;
        lo    = 8'hff;
        // a latched ff can carry into the live high byte, so read again
        while (lo == 8'hff && tries < 8) begin
            at_cycle = cycle_cnt;
            bus_cycle(1'b1, XM_TIMER, 1'b0, 8'h00, hi);
            bus_cycle(1'b1, XM_TIMER, 1'b1, 8'h00, lo);
            tries++;
        end
        if (lo == 8'hff) abort_run("timer low byte stuck at ff");
        t = {hi, lo};
    endtask

    initial begin
        word_t rd_w;
        word_t exp_w;
        addr_t start;
        addr_t next_addr;
        word_t t1;
        word_t t2;
        word_t delta;
        int    c1;
        int    c2;
        int    gap;
        int    errs;
        logic  h_val;
        logic  v_val;
        byte_t lo_again;
        byte_t ignored;

        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        h_blank_i     = 1'b0;
        v_blank_i     = 1'b0;
        exp_mask      = 4'hf;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        repeat (4) @(posedge clk);

        errs        = errors;
        exp_rd_incr = word_t'($random(seed));
        exp_wr_incr = word_t'($random(seed));
        exp_wr_addr = addr_t'($random(seed));
        start       = addr_t'($random(seed));
        write_word(XM_RD_INCR, exp_rd_incr);
        write_word(XM_WR_INCR, exp_wr_incr);
        write_word(XM_WR_ADDR, exp_wr_addr);
        write_word(XM_RD_ADDR, start);
        wait_idle();
        exp_rd_addr = start + exp_rd_incr;  // advanced after the read it started
        read_word(XM_RD_INCR, rd_w);
        check_word("RD_INCR", rd_w, exp_rd_incr);
        read_word(XM_WR_INCR, rd_w);
        check_word("WR_INCR", rd_w, exp_wr_incr);
        read_word(XM_WR_ADDR, rd_w);
        check_word("WR_ADDR", rd_w, exp_wr_addr);
        read_word(XM_RD_ADDR, rd_w);
        check_word("RD_ADDR", rd_w, exp_rd_addr);
        end_test("address registers", errs);

        errs        = errors;
        exp_wr_incr = word_t'($random(seed));
        exp_wr_addr = addr_t'($random(seed));
        write_word(XM_WR_INCR, exp_wr_incr);
        write_word(XM_WR_ADDR, exp_wr_addr);
        stream_write(8);
        end_test("streaming writes", errs);

        errs        = errors;
        exp_rd_incr = word_t'($random(seed));
        start       = addr_t'($random(seed));
        write_word(XM_RD_INCR, exp_rd_incr);
        write_word(XM_RD_ADDR, start);
        wait_idle();
        next_addr   = start;
        exp_rd_addr = start + exp_rd_incr;
        for (int i = 0; i < 8; i++) begin
            read_word(1'($random(seed)) ? XM_DATA_2 : XM_DATA, rd_w);
            check_word("DATA stream", rd_w, vram_mem[next_addr]);
            wait_idle();                    // pre-read of the next word
            next_addr   = next_addr + exp_rd_incr;
            exp_rd_addr = exp_rd_addr + exp_rd_incr;
        end
        read_word(XM_RD_ADDR, rd_w);
        check_word("RD_ADDR after reads", rd_w, exp_rd_addr);
        end_test("streaming reads", errs);

        errs     = errors;
        exp_mask = 4'($random(seed));
        h_val    = 1'($random(seed));
        v_val    = 1'($random(seed));
        @(posedge clk);
        h_blank_i <= h_val;
        v_blank_i <= v_val;
        bus_cycle(1'b0, XM_SYS_CTRL, 1'b1, {4'h0, exp_mask}, ignored);
        read_word(XM_SYS_CTRL, rd_w);
        exp_w                 = '0;
        exp_w[SYS_HBLANK_BIT] = h_val;
        exp_w[SYS_VBLANK_BIT] = v_val;
        exp_w[WRMASK_W-1:0]   = exp_mask;
        check_word("SYS_CTRL", rd_w, exp_w);
        stream_write(4);
        for (int i = 0; i < 8; i++) begin
            write_word(dropped_regs[i], word_t'($random(seed)));
            read_word(dropped_regs[i], rd_w);
            check_word("dropped register", rd_w, 16'h0000);
        end
        end_test("mask, status and dropped registers", errs);

        errs = errors;
        read_timer(t1, c1);
        gap = 60 + int'($unsigned($random(seed)) % 32'd200);
        repeat (gap) @(posedge clk);
        read_timer(t2, c2);
        delta = t2 - t1;
        if (int'(delta) < (c2 - c1) / CLK_DIV - 2 || int'(delta) > (c2 - c1) / CLK_DIV + 2) begin
            $display("Fail @%0t: timer moved by %0d over %0d cycles", $time, delta, c2 - c1);
            errors++;
        end
        repeat (30) @(posedge clk);
        bus_cycle(1'b1, XM_TIMER, 1'b1, 8'h00, lo_again);
        if (lo_again !== t2[7:0]) begin
            $display("Fail @%0t: timer low byte changed to %h from %h", $time, lo_again,
                     t2[7:0]);
            errors++;
        end
        end_test("timer", errs);

        errors = errors + u_dut.u_reg_file.u_reg_asserts.assert_failures;
        $display("done: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* xm_regs.f */
hdl/xm_pkg.sv
hdl/bus_sync.sv
hdl/tick_timer.sv
hdl/xm_reg_file.sv
hdl/xm_regs.sv
dv/xm_regs_asserts.sv
dv/tb_xm_regs.sv

/* Makefile */
# Verilator lint, build and simulation of the host register interface

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_xm_regs
RTL_TOP   := xm_regs
FILELIST  := xm_regs.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
